/* src/ql_clock_pkg.sv */
// Shared widths, channel indices, rate constants and speed encoding, imported by every RTL block
`default_nettype none

package ql_clock_pkg;

	// ========================================
	// Accumulator channels
	// ========================================

	localparam int NUM_CH = 3;          // Bus, SD and IPC accumulators
	localparam int CH_BUS = 0;          // CPU bus clock
	localparam int CH_SD  = 1;          // QL-SD strobe
	localparam int CH_11M = 2;          // IPC strobe

	localparam int ACC_W = 16;          // Phase register width
	localparam int INC_W = 17;          // One extra bit so the Full step of 2^16 fits

	typedef logic [ACC_W-1:0] acc_t;
	typedef logic [INC_W-1:0] inc_t;

	// CPU speed selection, same codes as the OSD menu order
	typedef enum logic [1:0]
	{
		SPEED_QL   = 2'd0,
		SPEED_16   = 2'd1,
		SPEED_24   = 2'd2,
		SPEED_FULL = 2'd3
	} cpu_speed_e;

	// ========================================
	// Increments for an 84 MHz clk_sys
	// ========================================

	// Rate is 84 MHz * inc / 65536
	localparam inc_t INC_BUS_QL   = 17'd11702;   // ~15 MHz bus, two phases
	localparam inc_t INC_BUS_16   = 17'd24966;   // ~32 MHz
	localparam inc_t INC_BUS_24   = 17'd37449;   // ~48 MHz
	localparam inc_t INC_BUS_FULL = 17'd65536;   // Tick every cycle

	localparam inc_t INC_SD  = 17'd19505;        // SD strobe, SPI runs at half of it
	localparam inc_t INC_11M = 17'd8582;         // ~11 MHz for the IPC

	// ========================================
	// Integer dividers
	// ========================================

	localparam int DIV_W    = 10;       // Wide enough for the refresh divisor
	localparam int DIV_131K = 640;      // 131.25 kHz refresh and RTC tick
	localparam int DIV_VID  = 8;        // 10.5 MHz pixel strobe

endpackage

`default_nettype wire

/* src/ce_accum_if.sv */
// Bundle of per-channel increments and carry ticks shared by selector, accumulators and splitter
`timescale 1ns/1ps
`default_nettype none

interface ce_accum_if;
	import ql_clock_pkg::*;

	// Step per clk_sys, one per channel, held as a level
	inc_t incr [NUM_CH];

	// Registered carry out, single cycle pulse per channel
	logic tick [NUM_CH];

	// Rate selector side
	modport source
	(
		output incr
	);

	// Each accumulator reads its step and returns its carry
	modport channel
	(
		input  incr,
		output tick
	);

	// Phase splitter only consumes the ticks
	modport sink
	(
		input  tick
	);

endinterface

`default_nettype wire

/* src/ce_rate_select.sv */
// Latches the CPU speed while in reset and drives the step of every accumulator channel
`timescale 1ns/1ps
`default_nettype none

module ce_rate_select
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [1:0]        cpu_speed,    // From the OSD, may change at any time
	ce_accum_if.source        acc
);
	import ql_clock_pkg::*;

	cpu_speed_e speed_q;    // Speed in effect until the next reset
	inc_t       bus_inc;

	// Follows the menu only while reset is high, so the bus rate
	// never jumps under a running CPU
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			speed_q <= cpu_speed_e'(cpu_speed);
	end

	// Bus step per speed
	always_comb
	begin
		case (speed_q)
			SPEED_QL:   bus_inc = INC_BUS_QL;
			SPEED_16:   bus_inc = INC_BUS_16;
			SPEED_24:   bus_inc = INC_BUS_24;
			SPEED_FULL: bus_inc = INC_BUS_FULL;
			default:    bus_inc = INC_BUS_QL;    // Unreachable with 2-bit code
		endcase
	end

	// ========================================
	// Channel steps
	// ========================================

	assign acc.incr[CH_BUS] = bus_inc;
	assign acc.incr[CH_SD]  = INC_SD;      // Fixed, independent of CPU speed
	assign acc.incr[CH_11M] = INC_11M;     // Fixed as well

endmodule

`default_nettype wire

/* src/frac_accum_channel.sv */
// One fractional phase accumulator, emits a registered carry tick for its channel of the bundle
`timescale 1ns/1ps
`default_nettype none

module frac_accum_channel
#(
	parameter int CH = ql_clock_pkg::CH_BUS    // Element of the bundle this instance owns
)
(
	input  logic              clk_sys,
	input  logic              reset,
	ce_accum_if.channel       acc
);
	import ql_clock_pkg::*;

	acc_t             phase_q;    // Fractional part of the phase
	logic             tick_q;     // Carry of the last add
	logic [ACC_W:0]   sum;        // Phase plus step, carry in the top bit

	// Step is at most 2^ACC_W, so one carry bit is enough
	assign sum = {1'b0, phase_q} + acc.incr[CH];

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			phase_q <= '0;
			tick_q  <= 1'b0;
		end
		else
		begin
			phase_q <= sum[ACC_W-1:0];    // Wraps modulo 2^ACC_W
			tick_q  <= sum[ACC_W];        // Full step carries every cycle
		end
	end

	// Average tick rate is clk_sys * incr / 2^ACC_W
	assign acc.tick[CH] = tick_q;

endmodule

`default_nettype wire

/* src/ce_phase_split.sv */
// Splits the bus tick into alternating phase-1 and phase-2 enables and retimes the SD and IPC ticks
`timescale 1ns/1ps
`default_nettype none

module ce_phase_split
(
	input  logic              clk_sys,
	input  logic              reset,
	ce_accum_if.sink          acc,
	output logic              ce_bus_p,     // Phase 1 enable for the CPU
	output logic              ce_bus_n,     // Phase 2 enable
	output logic              ce_sd,
	output logic              ce_11m
);
	import ql_clock_pkg::*;

	logic bus_pol;    // Low means the next bus tick is phase 1
	logic bus_tick;

	assign bus_tick = acc.tick[CH_BUS];

	// ========================================
	// Bus phase steering
	// ========================================

	// Each tick goes to exactly one phase, so p and n never coincide
	// and strictly alternate
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			bus_pol  <= 1'b0;    // First tick after reset is phase 1
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
		end
		else
		begin
			ce_bus_p <= bus_tick & ~bus_pol;
			ce_bus_n <= bus_tick &  bus_pol;
			bus_pol  <= bus_pol ^ bus_tick;    // Flip only on a tick
		end
	end

	// Same one-edge delay as the bus path
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			ce_sd  <= 1'b0;
			ce_11m <= 1'b0;
		end
		else
		begin
			ce_sd  <= acc.tick[CH_SD];
			ce_11m <= acc.tick[CH_11M];
		end
	end

endmodule

`default_nettype wire

/* src/ce_int_divider.sv */
// Wrapping integer counter that strobes one clk_sys cycle per divisor period
`timescale 1ns/1ps
`default_nettype none

module ce_int_divider
#(
	parameter int DIV = ql_clock_pkg::DIV_VID    // Period in clk_sys cycles, 2 to 2^DIV_W
)
(
	input  logic              clk_sys,
	input  logic              reset,
	output logic              ce            // High one cycle in every DIV
);
	import ql_clock_pkg::*;

	localparam logic [DIV_W-1:0] LAST = DIV_W'(DIV - 1);    // Wrap point

	logic [DIV_W-1:0] count;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			count <= '0;
			ce    <= 1'b0;
		end
		else
		begin
			ce <= (count == '0);    // First strobe right after reset drops
			if (count == LAST)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/ql_clock_gen.sv */
// Clock-enable generator top, instantiates all strobe blocks and exposes them as plain ports
`timescale 1ns/1ps
`default_nettype none

module ql_clock_gen
(
	input  logic              clk_sys,      // 84 MHz system clock
	input  logic              reset,
	input  logic [1:0]        cpu_speed,    // QL, 16, 24 or Full
	output logic              ce_bus_p,
	output logic              ce_bus_n,
	output logic              ce_sd,
	output logic              ce_11m,
	output logic              ce_131k,      // SDRAM refresh and RTC
	output logic              ce_vid        // Pixel strobe
);
	import ql_clock_pkg::*;

	ce_accum_if acc_if ();

	// ========================================
	// Fractional strobes
	// ========================================

	ce_rate_select i_rate_select
	(
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_speed (cpu_speed),
		.acc       (acc_if.source)
	);

	// Bus, SD and IPC accumulators, identical apart from the step
	for (genvar ch = 0; ch < NUM_CH; ch++)
	begin : g_ch
		frac_accum_channel #(.CH(ch)) i_accum
		(
			.clk_sys (clk_sys),
			.reset   (reset),
			.acc     (acc_if.channel)
		);
	end

	ce_phase_split i_phase_split
	(
		.clk_sys  (clk_sys),
		.reset    (reset),
		.acc      (acc_if.sink),
		.ce_bus_p (ce_bus_p),
		.ce_bus_n (ce_bus_n),
		.ce_sd    (ce_sd),
		.ce_11m   (ce_11m)
	);

	// ========================================
	// Integer strobes
	// ========================================

	ce_int_divider #(.DIV(DIV_131K)) i_div_131k
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce_131k)
	);

	ce_int_divider #(.DIV(DIV_VID)) i_div_vid
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce_vid)
	);

endmodule

`default_nettype wire

/* verification/ce_monitor.sv */
// Checker beside the DUT that steps a cycle model of every enable and compares it each cycle
`timescale 1ns/1ps
`default_nettype none

module ce_monitor
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [1:0] cpu_speed,
	input  logic       ce_bus_p,
	input  logic       ce_bus_n,
	input  logic       ce_sd,
	input  logic       ce_11m,
	input  logic       ce_131k,
	input  logic       ce_vid,
	input  int         test_num,
	input  logic       test_done,     // Report and clear the per-test count
	output int         error_count,
	output int         check_count,
	output int         failed_tests
);
	import ql_clock_pkg::*;

	// Model state as seen after the last rising edge
	logic [1:0] m_speed;
	acc_t       m_phase [NUM_CH];
	logic       m_tick [NUM_CH];
	logic       m_pol;
	int         m_cnt_131k;
	int         m_cnt_vid;

	logic [5:0] exp_out;        // {bus_p, bus_n, sd, 11m, 131k, vid}
	logic [5:0] act;
	logic       last_was_p;
	logic       any_phase;
	int         run_cycle;      // Cycle 1 is the first edge out of reset
	int         test_errors;

	initial
	begin
		error_count  = 0;
		check_count  = 0;
		failed_tests = 0;
		test_errors  = 0;
		run_cycle    = 0;
		last_was_p   = 1'b0;
		any_phase    = 1'b0;
	end

	function automatic string speed_tag(input logic [1:0] s);
		case (s)
			2'd0:    return "speed_ql";
			2'd1:    return "speed_16";
			2'd2:    return "speed_24";
			default: return "speed_full";
		endcase
	endfunction

	function automatic string test_name(input int n);
		return $sformatf("test%0d_%s", n, speed_tag(m_speed));
	endfunction

	function automatic string out_name(input int b);
		case (b)
			5:       return "ce_bus_p";
			4:       return "ce_bus_n";
			3:       return "ce_sd";
			2:       return "ce_11m";
			1:       return "ce_131k";
			default: return "ce_vid";
		endcase
	endfunction

	// Step per channel with the bus step taken from the latched speed
	function automatic inc_t channel_step(input int c);
		if (c == CH_SD)
			return INC_SD;
		if (c == CH_11M)
			return INC_11M;
		case (m_speed)
			2'd0:    return INC_BUS_QL;
			2'd1:    return INC_BUS_16;
			2'd2:    return INC_BUS_24;
			default: return INC_BUS_FULL;
		endcase
	endfunction

	// ========================================
	// Reference model called once per rising edge
	// ========================================

	function automatic logic [5:0] ref_step(input logic rst, input logic [1:0] spd);
		logic [5:0]     nxt;
		logic [ACC_W:0] sum;
		nxt = '0;    // All outputs low in and right after reset
		if (rst)
		begin
			m_speed    = spd;    // Follows the input only during reset
			m_pol      = 1'b0;
			m_cnt_131k = 0;
			m_cnt_vid  = 0;
			for (int c = 0; c < NUM_CH; c++)
			begin
				m_phase[c] = '0;
				m_tick[c]  = 1'b0;
			end
		end
		else
		begin
			// Outputs come from the ticks of the previous edge
			nxt[5] = m_tick[CH_BUS] & ~m_pol;
			nxt[4] = m_tick[CH_BUS] & m_pol;
			nxt[3] = m_tick[CH_SD];
			nxt[2] = m_tick[CH_11M];
			nxt[1] = (m_cnt_131k == 0);
			nxt[0] = (m_cnt_vid == 0);
			m_pol      = m_pol ^ m_tick[CH_BUS];
			m_cnt_131k = (m_cnt_131k + 1) % DIV_131K;
			m_cnt_vid  = (m_cnt_vid + 1) % DIV_VID;
			for (int c = 0; c < NUM_CH; c++)
			begin
				sum        = {1'b0, m_phase[c]} + channel_step(c);
				m_tick[c]  = sum[ACC_W];        // Carry out
				m_phase[c] = sum[ACC_W-1:0];
			end
		end
		return nxt;
	endfunction

	// ========================================
	// Compare with inputs taken at the edge and outputs at the falling edge
	// ========================================

	always @(posedge clk_sys)
	begin
		exp_out = ref_step(reset, cpu_speed);
		if (reset)
		begin
			run_cycle = 0;
			any_phase = 1'b0;
		end
		else
			run_cycle = run_cycle + 1;
		@(negedge clk_sys);
		act = {ce_bus_p, ce_bus_n, ce_sd, ce_11m, ce_131k, ce_vid};
		for (int b = 5; b >= 0; b--)
		begin
			check_count++;
			if (act[b] !== exp_out[b])
			begin
				error_count++;
				test_errors++;
				$display("FAILED %s cycle %0d %s: expected %0b, actual %0b",
					test_name(test_num), run_cycle, out_name(b), exp_out[b], act[b]);
			end
		end
		// Phase order on its own as p then n then p
		if (ce_bus_p || ce_bus_n)
		begin
			if (any_phase && (last_was_p == ce_bus_p))
			begin
				error_count++;
				test_errors++;
				$display("Error in %s at cycle %0d: %s enable came twice in a row",
					test_name(test_num), run_cycle, ce_bus_p ? "phase-1" : "phase-2");
			end
			any_phase  = 1'b1;
			last_was_p = ce_bus_p;
		end
		if (test_done)
		begin
			if (test_errors == 0)
				$display("%s: pass, %0d cycles checked", test_name(test_num), run_cycle);
			else
			begin
				failed_tests++;
				$display("%s: fail, %0d mismatches", test_name(test_num), test_errors);
			end
			test_errors = 0;
		end
	end

endmodule

`default_nettype wire

/* verification/ql_clock_gen_properties.sv */
// Concurrent checks on the enable outputs, bound into every instance of the generator top
`timescale 1ns/1ps
`default_nettype none

module ql_clock_gen_properties
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [1:0] cpu_speed,
	input  logic       ce_bus_p,
	input  logic       ce_bus_n,
	input  logic       ce_sd,
	input  logic       ce_11m,
	input  logic       ce_131k,
	input  logic       ce_vid
);
	import ql_clock_pkg::*;

	logic seen_reset = 1'b0;    // Outputs unknown before the first reset edge
	logic full_q     = 1'b0;    // Speed latched like the rate selector

	always @(posedge clk_sys)
	begin
		if (reset)
		begin
			seen_reset <= 1'b1;
			full_q     <= (cpu_speed == SPEED_FULL);
		end
	end

	// Phases never overlap
	a_no_overlap: assert property (@(posedge clk_sys) disable iff (!seen_reset)
		!(ce_bus_p && ce_bus_n))
		else $error("ce_bus_p and ce_bus_n high in the same cycle");

	a_quiet_after_reset: assert property (@(posedge clk_sys) disable iff (!seen_reset)
		reset |=> !(ce_bus_p || ce_bus_n || ce_sd || ce_11m || ce_131k || ce_vid))
		else $error("enable output high in the cycle after reset");

	// Two edges out of reset at Full, one phase every cycle
	a_full_every_cycle: assert property (@(posedge clk_sys) disable iff (!seen_reset)
		(full_q && !$past(reset, 1) && !$past(reset, 2)) |-> (ce_bus_p ^ ce_bus_n))
		else $error("no single bus phase enable in a Full speed cycle");

endmodule

bind ql_clock_gen ql_clock_gen_properties i_properties
(
	.clk_sys   (clk_sys),
	.reset     (reset),
	.cpu_speed (cpu_speed),
	.ce_bus_p  (ce_bus_p),
	.ce_bus_n  (ce_bus_n),
	.ce_sd     (ce_sd),
	.ce_11m    (ce_11m),
	.ce_131k   (ce_131k),
	.ce_vid    (ce_vid)
);

`default_nettype wire

/* verification/ql_clock_gen_tb.sv */
// Testbench top for the clock-enable generator, runs one test per CPU speed in an LFSR-chosen order
`timescale 1ns/1ps
`default_nettype none

module ql_clock_gen_tb;
	import ql_clock_pkg::*;

	// ========================================
	// Run length
	// ========================================

	localparam int NUM_TESTS    = 4;       // One per CPU speed
	localparam int RESET_CYCLES = 16;
	localparam int TEST_CYCLES  = 2000;
	localparam int RUN_CYCLES   = NUM_TESTS * (RESET_CYCLES + TEST_CYCLES + 1);
	localparam int CYCLE_LIMIT  = RUN_CYCLES + RUN_CYCLES / 10;    // 10% margin

	localparam logic [31:0] LFSR_SEED = 32'hc4d28018;
	localparam logic [31:0] LFSR_MASK = 32'h80200003;    // x^32 + x^22 + x^2 + x + 1

	logic        clk_sys;
	logic        reset;
	logic [1:0]  cpu_speed;
	logic        ce_bus_p;
	logic        ce_bus_n;
	logic        ce_sd;
	logic        ce_11m;
	logic        ce_131k;
	logic        ce_vid;

	int          test_num;       // Running test, 1 based
	logic        test_done;      // One cycle at the end of each test
	int          error_count;
	int          check_count;
	int          failed_tests;
	int          cycle_count;
	logic [31:0] lfsr_state;
	logic        speed_used [4];

	ql_clock_gen i_dut
	(
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_speed (cpu_speed),
		.ce_bus_p  (ce_bus_p),
		.ce_bus_n  (ce_bus_n),
		.ce_sd     (ce_sd),
		.ce_11m    (ce_11m),
		.ce_131k   (ce_131k),
		.ce_vid    (ce_vid)
	);

	ce_monitor i_monitor
	(
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_speed    (cpu_speed),
		.ce_bus_p     (ce_bus_p),
		.ce_bus_n     (ce_bus_n),
		.ce_sd        (ce_sd),
		.ce_11m       (ce_11m),
		.ce_131k      (ce_131k),
		.ce_vid       (ce_vid),
		.test_num     (test_num),
		.test_done    (test_done),
		.error_count  (error_count),
		.check_count  (check_count),
		.failed_tests (failed_tests)
	);

	always #20 clk_sys = ~clk_sys;    // 40 ns period

	// Galois step, shift right and fold the mask on a set LSB
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
	endfunction

	function automatic logic take_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);    // One step per bit
		return b;
	endfunction

	// Two random bits, then the next speed not yet run
	function automatic logic [1:0] pick_speed();
		logic [1:0] s;
		s[1] = take_bit();
		s[0] = take_bit();
		while (speed_used[s])
			s = s + 2'd1;
		speed_used[s] = 1'b1;
		return s;
	endfunction

	// Reset with a decoy speed first, the real one in the last half of reset
	task automatic run_test(input int n, input logic [1:0] spd);
		@(posedge clk_sys);
		#2;
		test_done = 1'b0;
		test_num  = n;
		reset     = 1'b1;
		cpu_speed = ~spd;
		repeat (RESET_CYCLES / 2) @(posedge clk_sys);
		#2 cpu_speed = spd;    // Last value seen in reset wins
		repeat (RESET_CYCLES / 2) @(posedge clk_sys);
		#2 reset = 1'b0;
		repeat (TEST_CYCLES) @(posedge clk_sys);
		#2 test_done = 1'b1;
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		logic [1:0] spd;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		cpu_speed   = SPEED_QL;
		test_num    = 0;
		test_done   = 1'b0;
		cycle_count = 0;
		lfsr_state  = LFSR_SEED;
		for (int i = 0; i < 4; i++)
			speed_used[i] = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			spd = pick_speed();
			run_test(t + 1, spd);
		end
		@(posedge clk_sys);    // Monitor reports the last test meanwhile
		#2 test_done = 1'b0;
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			NUM_TESTS, failed_tests, check_count, error_count);
		if (error_count == 0 && failed_tests == 0 && check_count > 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Hang guard
	always @(posedge clk_sys)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* all.f */
src/ql_clock_pkg.sv
src/ce_accum_if.sv
src/ce_rate_select.sv
src/frac_accum_channel.sv
src/ce_phase_split.sv
src/ce_int_divider.sv
src/ql_clock_gen.sv
verification/ce_monitor.sv
verification/ql_clock_gen_properties.sv
verification/ql_clock_gen_tb.sv

/* Makefile */
# Verilator build and run of the clock-enable generator testbench

VERILATOR ?= verilator
TOP       ?= ql_clock_gen_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
